//--- core_config.svh
// Core configuration for the decode-to-execute pipeline slice.
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN 32
`define CORE_NREGS 32
`define CORE_REG_AW ($clog2(`CORE_NREGS))

// PC held by the pipeline registers after reset.
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- isa_pkg.sv
// Instruction set encodings and word formats of the MIPS-style integer subset.
`default_nettype none

package isa_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same word seen as R or I format; J target is the low 26 bits of the I view.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

endpackage

`default_nettype wire

//--- pipe_pkg.sv
// Pipeline control, stage payload and port bundle types for decode and execute.
`default_nettype none

`include "core_config.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        JUMP_NONE,
        JUMP_J,
        JUMP_JAL,
        JUMP_JR
    } jump_e;

    // Memory access sizes.
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef struct packed {
        logic                    mem_read;
        logic                    mem_write;
        logic                    alu_src_a;
        logic                    alu_src_b;
        logic                    reg_write;
        logic                    sign;
        logic                    branch_ne;
        logic                    is_branch;
        jump_e                   jump;
        logic                    wb_pc4;
        logic [1:0]              mem_size;
        alu_op_e                 alu_op;
        logic [`CORE_REG_AW-1:0] dest;
    } ctrl_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        isa_pkg::inst_u        inst;
        logic                  valid;
    } fetch_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] pc4;
        isa_pkg::inst_u        inst;
        logic [`CORE_XLEN-1:0] rs_data;
        logic [`CORE_XLEN-1:0] rt_data;
        logic [`CORE_XLEN-1:0] sext;
        logic [`CORE_XLEN-1:0] branch_addr;
    } id_ex_t;

    typedef struct packed {
        logic                    enable;
        logic [`CORE_REG_AW-1:0] dest;
        logic [`CORE_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [1:0]            size;
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  taken;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

    // Turns a payload into a bubble; pc and pc4 survive.
    function automatic id_ex_t make_bubble(input id_ex_t in);
        id_ex_t out;
        out = in;
        out.inst = '0;
        out.ctrl.reg_write = 1'b0;
        out.ctrl.mem_read = 1'b0;
        out.ctrl.mem_write = 1'b0;
        out.ctrl.is_branch = 1'b0;
        out.ctrl.jump = JUMP_NONE;
        return out;
    endfunction

endpackage

`default_nettype wire

//--- reg_file.sv
// Register file with two read ports, one write port and same-cycle write bypass.
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [`CORE_REG_AW-1:0] rs_addr,
    input  wire logic [`CORE_REG_AW-1:0] rt_addr,
    output logic [`CORE_XLEN-1:0]        rs_data,
    output logic [`CORE_XLEN-1:0]        rt_data,
    input  wire pipe_pkg::wb_t           wb
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int n = 0; n < `CORE_NREGS; n++) begin
                regs[n] <= '0;
            end
        end else if (wb.enable && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Register zero reads zero; a write in flight is forwarded.
    function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb.enable && wb.dest == addr)
            return wb.data;
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

`default_nettype wire

//--- id_stage.sv
// Decode stage: control decode, register read, immediate extension, branch target.
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module id_stage (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire pipe_pkg::fetch_t fetch,
    input  wire pipe_pkg::wb_t    wb,
    output pipe_pkg::id_ex_t      decoded
);

    isa_pkg::r_fmt_t       r;
    isa_pkg::i_fmt_t       iw;
    pipe_pkg::ctrl_t       ctrl;
    logic                  known;
    logic [`CORE_XLEN-1:0] pc4;
    logic [`CORE_XLEN-1:0] rs_data;
    logic [`CORE_XLEN-1:0] rt_data;
    logic [`CORE_XLEN-1:0] sext;

    assign r = fetch.inst.r;
    assign iw = fetch.inst.i;
    assign pc4 = fetch.pc + 4;

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (iw.rs),
        .rt_addr (iw.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    always_comb begin
        ctrl = '0;
        known = 1'b1;
        case (iw.opcode)
            isa_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.dest = r.rd;
                case (r.funct)
                    isa_pkg::FN_ADD: ctrl.alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: ctrl.alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND: ctrl.alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:  ctrl.alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_XOR: ctrl.alu_op = pipe_pkg::ALU_XOR;
                    isa_pkg::FN_SLT: ctrl.alu_op = pipe_pkg::ALU_SLT;
                    isa_pkg::FN_SLL, isa_pkg::FN_SRL: begin
                        ctrl.alu_src_a = 1'b1;
                        ctrl.alu_op = r.funct == isa_pkg::FN_SLL ? pipe_pkg::ALU_SLL
                                                                 : pipe_pkg::ALU_SRL;
                    end
                    isa_pkg::FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.dest = '0;
                        ctrl.jump = pipe_pkg::JUMP_JR;
                    end
                    default: known = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_SLTI, isa_pkg::OP_ANDI,
            isa_pkg::OP_ORI, isa_pkg::OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_b = 1'b1;
                ctrl.dest = iw.rt;
                ctrl.sign = iw.opcode inside {isa_pkg::OP_ADDI, isa_pkg::OP_SLTI};
                case (iw.opcode)
                    isa_pkg::OP_SLTI: ctrl.alu_op = pipe_pkg::ALU_SLT;
                    isa_pkg::OP_ANDI: ctrl.alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::OP_ORI:  ctrl.alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::OP_LUI:  ctrl.alu_op = pipe_pkg::ALU_LUI;
                    default:          ctrl.alu_op = pipe_pkg::ALU_ADD;
                endcase
            end
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW,
            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
                // Opcode bit 3 marks a store; bits 1:0 give the size.
                ctrl.mem_read = !iw.opcode[3];
                ctrl.mem_write = iw.opcode[3];
                ctrl.alu_src_b = 1'b1;
                ctrl.sign = 1'b1;
                ctrl.dest = iw.opcode[3] ? '0 : iw.rt;
                ctrl.mem_size = iw.opcode[1] ? pipe_pkg::SIZE_WORD
                              : iw.opcode[0] ? pipe_pkg::SIZE_HALF : pipe_pkg::SIZE_BYTE;
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = iw.opcode == isa_pkg::OP_BNE;
                ctrl.sign = 1'b1;
                ctrl.alu_op = pipe_pkg::ALU_SUB;
            end
            isa_pkg::OP_J: ctrl.jump = pipe_pkg::JUMP_J;
            isa_pkg::OP_JAL: begin
                ctrl.jump = pipe_pkg::JUMP_JAL;
                ctrl.reg_write = 1'b1;
                ctrl.wb_pc4 = 1'b1;
                ctrl.dest = 5'd31;
            end
            default: known = 1'b0;
        endcase
    end

    assign sext = ctrl.sign ? {{(`CORE_XLEN-16){iw.imm[15]}}, iw.imm}
                            : {{(`CORE_XLEN-16){1'b0}}, iw.imm};

    always_comb begin
        decoded.ctrl = ctrl;
        decoded.pc = fetch.pc;
        decoded.pc4 = pc4;
        decoded.inst = fetch.inst;
        decoded.rs_data = rs_data;
        decoded.rt_data = rt_data;
        decoded.sext = sext;
        decoded.branch_addr = pc4 + {sext[`CORE_XLEN-3:0], 2'b00};
        // Empty slots and unknown opcodes.
        if (!(fetch.valid && known))
            decoded = pipe_pkg::make_bubble(decoded);
    end

endmodule

`default_nettype wire

//--- id_ex_pipe.sv
// ID/EX pipeline register; a stall or a taken redirect loads a bubble.
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module id_ex_pipe (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              stall,
    input  wire logic              branch,
    input  wire pipe_pkg::id_ex_t  decoded,
    output pipe_pkg::id_ex_t       ex_in
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ex_in <= '0;
            ex_in.pc <= `CORE_RESET_PC;
            ex_in.pc4 <= `CORE_RESET_PC + 4;
        end else if (stall || branch) begin
            // Upstream holds its word on stall and replaces it on redirect.
            ex_in <= pipe_pkg::make_bubble(decoded);
        end else begin
            ex_in <= decoded;
        end
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
// Execute stage: ALU, branch and jump resolution, memory request and writeback.
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module ex_stage (
    input  wire pipe_pkg::id_ex_t ex_in,
    output pipe_pkg::wb_t         wb,
    output pipe_pkg::mem_req_t    mem_req,
    output pipe_pkg::redirect_t   redirect
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] result;
    logic [`CORE_XLEN-1:0] jump_target;
    logic                  lt;
    logic                  br_taken;

    // Shift instructions take shamt in place of rs.
    assign op_a = ex_in.ctrl.alu_src_a ? {{(`CORE_XLEN-5){1'b0}}, ex_in.inst.r.shamt}
                                       : ex_in.rs_data;
    assign op_b = ex_in.ctrl.alu_src_b ? ex_in.sext : ex_in.rt_data;
    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex_in.ctrl.alu_op)
            pipe_pkg::ALU_ADD:  result = op_a + op_b;
            pipe_pkg::ALU_SUB:  result = op_a - op_b;
            pipe_pkg::ALU_AND:  result = op_a & op_b;
            pipe_pkg::ALU_OR:   result = op_a | op_b;
            pipe_pkg::ALU_XOR:  result = op_a ^ op_b;
            pipe_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, lt};
            pipe_pkg::ALU_SLL:  result = op_b << op_a[4:0];
            pipe_pkg::ALU_SRL:  result = op_b >> op_a[4:0];
            pipe_pkg::ALU_LUI:  result = {op_b[15:0], 16'h0000};
            pipe_pkg::ALU_PASS: result = op_b;
            default:            result = '0;
        endcase
    end

    assign br_taken = ex_in.ctrl.is_branch &&
                      ((ex_in.rs_data == ex_in.rt_data) != ex_in.ctrl.branch_ne);

    // jr goes to rs; j and jal stay in the current 256 MB region.
    assign jump_target = ex_in.ctrl.jump == pipe_pkg::JUMP_JR ? ex_in.rs_data
                       : {ex_in.pc4[`CORE_XLEN-1:`CORE_XLEN-4], ex_in.inst.i.rs,
                          ex_in.inst.i.rt, ex_in.inst.i.imm, 2'b00};

    assign redirect.taken = br_taken || ex_in.ctrl.jump != pipe_pkg::JUMP_NONE;
    assign redirect.target = br_taken ? ex_in.branch_addr : jump_target;

    assign wb.enable = ex_in.ctrl.reg_write;
    assign wb.dest = ex_in.ctrl.dest;
    assign wb.data = ex_in.ctrl.wb_pc4 ? ex_in.pc4 : result;

    assign mem_req.read = ex_in.ctrl.mem_read;
    assign mem_req.write = ex_in.ctrl.mem_write;
    assign mem_req.size = ex_in.ctrl.mem_size;
    assign mem_req.addr = result;
    assign mem_req.wdata = ex_in.rt_data;

endmodule

`default_nettype wire

//--- id_ex_core.sv
// Decode-to-execute slice: decode, ID/EX register and execute joined together.
`timescale 1ns/1ps
`default_nettype none

module id_ex_core (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire pipe_pkg::fetch_t fetch,
    input  wire logic             stall,
    output pipe_pkg::wb_t         wb,
    output pipe_pkg::mem_req_t    mem_req,
    output pipe_pkg::redirect_t   redirect
);

    pipe_pkg::id_ex_t decoded;
    pipe_pkg::id_ex_t ex_in;

    id_stage u_id_stage (
        .clk     (clk),
        .reset   (reset),
        .fetch   (fetch),
        .wb      (wb),
        .decoded (decoded)
    );

    id_ex_pipe u_id_ex_pipe (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .branch  (redirect.taken),
        .decoded (decoded),
        .ex_in   (ex_in)
    );

    ex_stage u_ex_stage (
        .ex_in    (ex_in),
        .wb       (wb),
        .mem_req  (mem_req),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

//--- tb_id_ex_core.sv
// Testbench for the decode-to-execute slice, driven from an instruction table.
`timescale 1ns/1ps
`default_nettype none

module tb_id_ex_core;

    typedef struct packed {
        logic        wb_en;
        logic [4:0]  wb_dest;
        logic [31:0] wb_data;
        logic        rd;
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        taken;
        logic [31:0] target;
    } want_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        stall;
        want_t       want;
    } row_t;

    logic                clk;
    logic                reset;
    logic                stall;
    pipe_pkg::fetch_t    fetch;
    pipe_pkg::wb_t       wb;
    pipe_pkg::mem_req_t  mem_req;
    pipe_pkg::redirect_t redirect;

    row_t        rows[$];
    logic [31:0] shadow [32];
    want_t       pending;
    int          cycles;
    int          limit;

    id_ex_core dut0 (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetch),
        .stall    (stall),
        .wb       (wb),
        .mem_req  (mem_req),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Run stopped after %0d cycles before the table was finished", limit);
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] r_word(input logic [5:0] funct, input int rd,
                                           input int rs, input int rt, input int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, input int rs,
                                           input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [25:0] tgt);
        return {op, tgt};
    endfunction

    // Expected effect of one instruction on the shadow register state.
    function automatic want_t model_row(input logic [31:0] inst, input logic [31:0] pc);
        want_t       w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] pc4;
        w = '0;
        a = shadow[inst[25:21]];
        b = shadow[inst[20:16]];
        simm = {{16{inst[15]}}, inst[15:0]};
        pc4 = pc + 32'd4;
        w.wb_en = 1'b1;
        w.wb_dest = inst[20:16];
        case (inst[31:26])
            isa_pkg::OP_RTYPE: begin
                w.wb_dest = inst[15:11];
                case (inst[5:0])
                    isa_pkg::FN_ADD: w.wb_data = a + b;
                    isa_pkg::FN_SUB: w.wb_data = a - b;
                    isa_pkg::FN_AND: w.wb_data = a & b;
                    isa_pkg::FN_OR:  w.wb_data = a | b;
                    isa_pkg::FN_XOR: w.wb_data = a ^ b;
                    isa_pkg::FN_SLT: w.wb_data = {31'b0, $signed(a) < $signed(b)};
                    isa_pkg::FN_SLL: w.wb_data = b << inst[10:6];
                    isa_pkg::FN_SRL: w.wb_data = b >> inst[10:6];
                    isa_pkg::FN_JR: begin
                        w.wb_en = 1'b0;
                        w.taken = 1'b1;
                        w.target = a;
                    end
                    default: w.wb_en = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDI: w.wb_data = a + simm;
            isa_pkg::OP_SLTI: w.wb_data = {31'b0, $signed(a) < $signed(simm)};
            isa_pkg::OP_ANDI: w.wb_data = a & {16'h0000, inst[15:0]};
            isa_pkg::OP_ORI:  w.wb_data = a | {16'h0000, inst[15:0]};
            isa_pkg::OP_LUI:  w.wb_data = {inst[15:0], 16'h0000};
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW,
            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
                w.wb_en = 1'b0;
                w.wr = inst[31:26] inside {isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW};
                w.rd = !w.wr;
                w.addr = a + simm;
                w.wdata = b;
                if (inst[31:26] inside {isa_pkg::OP_LW, isa_pkg::OP_SW})
                    w.size = 2'd2;
                else if (inst[31:26] inside {isa_pkg::OP_LH, isa_pkg::OP_SH})
                    w.size = 2'd1;
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                w.wb_en = 1'b0;
                w.taken = (a == b) == (inst[31:26] == isa_pkg::OP_BEQ);
                w.target = pc4 + (simm << 2);
            end
            isa_pkg::OP_J, isa_pkg::OP_JAL: begin
                w.wb_en = inst[31:26] == isa_pkg::OP_JAL;
                w.wb_dest = 5'd31;
                w.wb_data = pc4;
                w.taken = 1'b1;
                w.target = {pc4[31:28], inst[25:0], 2'b00};
            end
            default: w.wb_en = 1'b0;
        endcase
        return w;
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic st);
        row_t r;
        r = '0;
        r.inst = inst;
        r.stall = st;
        rows.push_back(r);
    endtask

    task automatic load_program();
        logic [31:0] filler;
        filler = i_word(isa_pkg::OP_ADDI, 20, 0, 16'd99);
        add_row(i_word(isa_pkg::OP_ADDI, 1, 0, 16'h1234), 1'b0);
        add_row(i_word(isa_pkg::OP_ADDI, 2, 0, 16'hfffb), 1'b0);
        add_row(r_word(isa_pkg::FN_ADD, 3, 1, 2, 0), 1'b0);
        add_row(r_word(isa_pkg::FN_SUB, 4, 1, 2, 0), 1'b0);
        add_row(r_word(isa_pkg::FN_AND, 5, 3, 1, 0), 1'b0);
        add_row(r_word(isa_pkg::FN_OR, 6, 1, 2, 0), 1'b0);
        add_row(r_word(isa_pkg::FN_XOR, 7, 1, 2, 0), 1'b0);
        add_row(r_word(isa_pkg::FN_SLT, 8, 2, 1, 0), 1'b0);
        add_row(r_word(isa_pkg::FN_SLL, 9, 0, 1, 4), 1'b0);
        add_row(r_word(isa_pkg::FN_SRL, 10, 0, 2, 8), 1'b0);
        add_row(i_word(isa_pkg::OP_ANDI, 11, 2, 16'hff00), 1'b0);
        add_row(i_word(isa_pkg::OP_ORI, 12, 0, 16'h8001), 1'b0);
        add_row(i_word(isa_pkg::OP_SLTI, 13, 2, 16'h0001), 1'b0);
        add_row(i_word(isa_pkg::OP_LUI, 14, 0, 16'habcd), 1'b0);
        // Register zero must stay zero for the next read.
        add_row(i_word(isa_pkg::OP_ADDI, 0, 0, 16'h0005), 1'b0);
        add_row(r_word(isa_pkg::FN_ADD, 15, 0, 1, 0), 1'b1);
        add_row(i_word(isa_pkg::OP_LW, 16, 1, 16'h0008), 1'b0);
        add_row(i_word(isa_pkg::OP_LH, 17, 1, 16'hfffe), 1'b0);
        add_row(i_word(isa_pkg::OP_LB, 18, 2, 16'h0003), 1'b0);
        add_row(i_word(isa_pkg::OP_SW, 3, 1, 16'h0004), 1'b1);
        add_row(i_word(isa_pkg::OP_SH, 4, 0, 16'h0000), 1'b0);
        add_row(i_word(isa_pkg::OP_SB, 7, 12, 16'h0001), 1'b0);
        add_row(i_word(isa_pkg::OP_BEQ, 2, 1, 16'h0004), 1'b0);
        add_row(i_word(isa_pkg::OP_BNE, 1, 1, 16'h0004), 1'b0);
        add_row(i_word(isa_pkg::OP_BEQ, 15, 1, 16'h0003), 1'b0);
        add_row(filler, 1'b0);
        add_row(i_word(isa_pkg::OP_BNE, 2, 1, 16'hfff8), 1'b1);
        add_row(filler, 1'b0);
        add_row(j_word(isa_pkg::OP_JAL, 26'h000100), 1'b0);
        add_row(filler, 1'b0);
        add_row(i_word(isa_pkg::OP_ADDI, 19, 31, 16'h0000), 1'b0);
        add_row(r_word(isa_pkg::FN_JR, 0, 1, 0, 0), 1'b0);
        add_row(filler, 1'b0);
        add_row(j_word(isa_pkg::OP_J, 26'h000080), 1'b0);
        add_row(filler, 1'b0);
        add_row(r_word(isa_pkg::FN_ADD, 21, 31, 19, 0), 1'b0);
    endtask

    // Walks the table in program order and fills in pc and expected results.
    task automatic predict_run();
        row_t        r;
        logic [31:0] pc;
        logic [31:0] target;
        logic        skip;
        pc = 32'h0000_0100;
        target = '0;
        skip = 1'b0;
        foreach (shadow[n])
            shadow[n] = '0;
        foreach (rows[n]) begin
            r = rows[n];
            r.pc = pc;
            pc = pc + 32'd4;
            if (skip) begin
                // Dropped word; fetch resumes at the redirect target.
                r.want = '0;
                skip = 1'b0;
                pc = target;
            end else begin
                r.want = model_row(r.inst, r.pc);
                if (r.want.wb_en && r.want.wb_dest != 5'd0)
                    shadow[r.want.wb_dest] = r.want.wb_data;
                skip = r.want.taken;
                target = r.want.target;
            end
            rows[n] = r;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("error: %s is %h, expected %h", name, got, want);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic match_outputs(input want_t w);
        check_value("wb.enable", 32'(wb.enable), 32'(w.wb_en));
        if (w.wb_en) begin
            check_value("wb.dest", 32'(wb.dest), 32'(w.wb_dest));
            check_value("wb.data", wb.data, w.wb_data);
        end
        check_value("mem_req.read", 32'(mem_req.read), 32'(w.rd));
        check_value("mem_req.write", 32'(mem_req.write), 32'(w.wr));
        if (w.rd || w.wr) begin
            check_value("mem_req.size", 32'(mem_req.size), 32'(w.size));
            check_value("mem_req.addr", mem_req.addr, w.addr);
        end
        if (w.wr)
            check_value("mem_req.wdata", mem_req.wdata, w.wdata);
        check_value("redirect.taken", 32'(redirect.taken), 32'(w.taken));
        if (w.taken)
            check_value("redirect.target", redirect.target, w.target);
    endtask

    // Outputs seen after an edge belong to the word applied one edge earlier.
    task automatic apply_word(input logic [31:0] inst, input logic [31:0] pc,
                              input logic valid, input logic st, input want_t w);
        @(posedge clk);
        fetch <= {pc, inst, valid};
        stall <= st;
        @(negedge clk);
        match_outputs(pending);
        pending = w;
    endtask

    initial begin
        reset = 1'b0;
        stall = 1'b0;
        fetch = '0;
        cycles = 0;
        pending = '0;
        load_program();
        predict_run();
        limit = 2 * rows.size() + 20;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        match_outputs('0);
        foreach (rows[n]) begin
            // A stalled word is held and shows up again with stall low.
            if (rows[n].stall)
                apply_word(rows[n].inst, rows[n].pc, 1'b1, 1'b1, '0);
            apply_word(rows[n].inst, rows[n].pc, 1'b1, 1'b0, rows[n].want);
        end
        apply_word('0, '0, 1'b0, 1'b0, '0);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
id_stage.sv
id_ex_pipe.sv
ex_stage.sv
id_ex_core.sv
tb_id_ex_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_id_ex_core
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)
